// ==== verilog/ext_pkg.sv ====
// external bus package
// bus widths, register offsets and the address rule table shared by the blocks
`default_nettype none

package ext_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int BE_W   = DATA_W / 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [BE_W-1:0]   be_t;

  // register targets behind the decoder
  localparam int NUM_TARGETS = 2;

  typedef logic [$clog2(NUM_TARGETS)-1:0] target_idx_t;

  localparam target_idx_t PWR_IDX    = 0;
  localparam target_idx_t MEMCFG_IDX = 1;

  typedef struct packed {
    target_idx_t idx;
    addr_t       start_addr;
    addr_t       end_addr;
  } addr_rule_t;

  // end addresses are inclusive
  localparam addr_rule_t EXT_ADDR_RULES [NUM_TARGETS] = '{
    '{idx: PWR_IDX,    start_addr: 32'h0000_0000, end_addr: 32'h0000_0FFF},
    '{idx: MEMCFG_IDX, start_addr: 32'h0000_1000, end_addr: 32'h0000_1FFF}
  };

  // word index inside a target
  localparam int REG_IDX_MSB = 11;
  localparam int REG_IDX_LSB = 2;

  localparam addr_t REG_SWITCH_OFFSET = 32'h0;
  localparam addr_t REG_ACK_OFFSET    = 32'h4;
  localparam addr_t REG_WAIT_OFFSET   = 32'h0;

  localparam int WAIT_W = 4;

endpackage

`default_nettype wire

// ==== verilog/ext_ifs.sv ====
// register bus and OBI interfaces used between the blocks of the external side
`default_nettype none

interface reg_bus_if;
  logic          valid;
  logic          write;
  ext_pkg::addr_t addr;
  ext_pkg::data_t wdata;
  ext_pkg::data_t rdata;
  logic          ready;

  modport host (
    output valid, write, addr, wdata,
    input  rdata, ready
  );

  modport target (
    input  valid, write, addr, wdata,
    output rdata, ready
  );
endinterface

interface obi_if;
  logic           req;
  logic           we;
  ext_pkg::be_t   be;
  ext_pkg::addr_t addr;
  ext_pkg::data_t wdata;
  logic           gnt;
  logic           rvalid;
  ext_pkg::data_t rdata;

  modport manager (
    output req, we, be, addr, wdata,
    input  gnt, rvalid, rdata
  );

  modport subordinate (
    input  req, we, be, addr, wdata,
    output gnt, rvalid, rdata
  );
endinterface

`default_nettype wire

// ==== verilog/reg_decode.sv ====
// register bus decoder
// matches the address against the rule table and steers the access to one target
`default_nettype none

module reg_decode (
  input  logic           reg_valid_i,
  input  logic           reg_write_i,
  input  ext_pkg::addr_t reg_addr_i,
  input  ext_pkg::data_t reg_wdata_i,
  output ext_pkg::data_t reg_rdata_o,
  output logic           reg_ready_o,
  output logic           reg_error_o,
  reg_bus_if.host        tgt_pwr,
  reg_bus_if.host        tgt_mem
);

  logic                 hit;
  ext_pkg::target_idx_t sel;

  // last matching rule wins, rules do not overlap anyway
  always_comb begin
    hit = 1'b0;
    sel = ext_pkg::PWR_IDX;
    for (int i = 0; i < ext_pkg::NUM_TARGETS; i++) begin
      if (reg_addr_i >= ext_pkg::EXT_ADDR_RULES[i].start_addr &&
          reg_addr_i <= ext_pkg::EXT_ADDR_RULES[i].end_addr) begin
        hit = 1'b1;
        sel = ext_pkg::EXT_ADDR_RULES[i].idx;
      end
    end
  end

  assign tgt_pwr.valid = reg_valid_i && hit && (sel == ext_pkg::PWR_IDX);
  assign tgt_pwr.write = reg_write_i;
  assign tgt_pwr.addr  = reg_addr_i;
  assign tgt_pwr.wdata = reg_wdata_i;

  assign tgt_mem.valid = reg_valid_i && hit && (sel == ext_pkg::MEMCFG_IDX);
  assign tgt_mem.write = reg_write_i;
  assign tgt_mem.addr  = reg_addr_i;
  assign tgt_mem.wdata = reg_wdata_i;

  // response mux, unmapped addresses answer at once with an error
  always_comb begin
    reg_rdata_o = '0;
    reg_ready_o = 1'b0;
    reg_error_o = 1'b0;
    if (!hit) begin
      reg_ready_o = reg_valid_i;
      reg_error_o = reg_valid_i;
    end else if (sel == ext_pkg::MEMCFG_IDX) begin
      reg_rdata_o = tgt_mem.rdata;
      reg_ready_o = tgt_mem.ready;
    end else begin
      reg_rdata_o = tgt_pwr.rdata;
      reg_ready_o = tgt_pwr.ready;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/power_ctrl_regs.sv ====
// power control registers
// active-low switch controls per domain and read-back of the switch acks
`default_nettype none

module power_ctrl_regs #(
  parameter int NUM_DOMAINS = 4
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  reg_bus_if.target              bus,
  output logic [NUM_DOMAINS-1:0] switch_n_o,
  input  logic [NUM_DOMAINS-1:0] ack_n_i
);

  logic [NUM_DOMAINS-1:0] switch_q;
  logic                   is_switch;
  logic                   is_ack;

  assign is_switch = bus.addr[ext_pkg::REG_IDX_MSB:ext_pkg::REG_IDX_LSB] ==
                     ext_pkg::REG_SWITCH_OFFSET[ext_pkg::REG_IDX_MSB:ext_pkg::REG_IDX_LSB];
  assign is_ack    = bus.addr[ext_pkg::REG_IDX_MSB:ext_pkg::REG_IDX_LSB] ==
                     ext_pkg::REG_ACK_OFFSET[ext_pkg::REG_IDX_MSB:ext_pkg::REG_IDX_LSB];

  // all domains powered after reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      switch_q <= '0;
    end else if (bus.valid && bus.write && is_switch) begin
      switch_q <= bus.wdata[NUM_DOMAINS-1:0];
    end
  end

  assign switch_n_o = switch_q;

  // single-cycle access, no wait
  assign bus.ready = bus.valid;

  always_comb begin
    bus.rdata = '0;
    if (is_switch) begin
      bus.rdata[NUM_DOMAINS-1:0] = switch_q;
    end else if (is_ack) begin
      bus.rdata[NUM_DOMAINS-1:0] = ack_n_i;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/switch_ack_delay.sv ====
// switch cell model
// returns each switch control as its ack after a fixed number of cycles
`default_nettype none

module switch_ack_delay #(
  parameter int NUM_DOMAINS        = 4,
  parameter int SWITCH_ACK_LATENCY = 15
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic [NUM_DOMAINS-1:0] switch_n_i,
  output logic [NUM_DOMAINS-1:0] ack_n_o
);

  logic [NUM_DOMAINS-1:0] stage_q [SWITCH_ACK_LATENCY];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < SWITCH_ACK_LATENCY; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= switch_n_i;
      for (int i = 1; i < SWITCH_ACK_LATENCY; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign ack_n_o = stage_q[SWITCH_ACK_LATENCY-1];

endmodule

`default_nettype wire

// ==== verilog/obi_fifo.sv ====
// OBI request FIFO
// buffers requests for the slow memory, responses pass straight back in order
`default_nettype none

module obi_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic           clk_i,
  input  logic           reset_i,
  input  logic           req_i,
  input  logic           we_i,
  input  ext_pkg::be_t   be_i,
  input  ext_pkg::addr_t addr_i,
  input  ext_pkg::data_t wdata_i,
  output logic           gnt_o,
  output logic           rvalid_o,
  output ext_pkg::data_t rdata_o,
  obi_if.manager         down
);

  localparam int PTR_W = FIFO_DEPTH > 1 ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  typedef enum logic [1:0] {
    FIFO_EMPTY,
    FIFO_PARTIAL,
    FIFO_FULL
  } fifo_state_e;

  fifo_state_e    state_q, state_d;
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] cnt_q, cnt_d;
  logic           push, pop;

  logic           we_mem    [FIFO_DEPTH];
  ext_pkg::be_t   be_mem    [FIFO_DEPTH];
  ext_pkg::addr_t addr_mem  [FIFO_DEPTH];
  ext_pkg::data_t wdata_mem [FIFO_DEPTH];

  assign gnt_o = (state_q != FIFO_FULL);
  assign push  = req_i && gnt_o;
  assign pop   = down.req && down.gnt;

  assign cnt_d = cnt_q + CNT_W'(push) - CNT_W'(pop);

  always_comb begin
    if (cnt_d == '0) begin
      state_d = FIFO_EMPTY;
    end else if (cnt_d == CNT_W'(FIFO_DEPTH)) begin
      state_d = FIFO_FULL;
    end else begin
      state_d = FIFO_PARTIAL;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q  <= FIFO_EMPTY;
      cnt_q    <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      we_mem[wr_ptr_q]    <= we_i;
      be_mem[wr_ptr_q]    <= be_i;
      addr_mem[wr_ptr_q]  <= addr_i;
      wdata_mem[wr_ptr_q] <= wdata_i;
    end
  end

  // oldest entry stays on the bus until the memory grants it
  assign down.req   = (state_q != FIFO_EMPTY);
  assign down.we    = we_mem[rd_ptr_q];
  assign down.be    = be_mem[rd_ptr_q];
  assign down.addr  = addr_mem[rd_ptr_q];
  assign down.wdata = wdata_mem[rd_ptr_q];

  assign rvalid_o = down.rvalid;
  assign rdata_o  = down.rdata;

endmodule

`default_nettype wire

// ==== verilog/slow_memory.sv ====
// slow word memory
// byte-enabled word array whose grant waits a programmable number of cycles
`default_nettype none

module slow_memory #(
  parameter int MEM_WORDS = 1024
) (
  input  logic       clk_i,
  input  logic       reset_i,
  obi_if.subordinate obi,
  reg_bus_if.target  cfg
);

  localparam int IDX_W = $clog2(MEM_WORDS);

  ext_pkg::data_t             mem_q [MEM_WORDS];
  logic [ext_pkg::WAIT_W-1:0] wait_q;
  logic [ext_pkg::WAIT_W-1:0] wait_cnt_q;
  logic [IDX_W-1:0]           idx;
  logic                       gnt;
  logic                       rvalid_q;
  ext_pkg::data_t             rdata_q;
  logic                       is_wait;

  assign idx = obi.addr[IDX_W+1:2];

  // >= keeps a pending request alive when the wait register shrinks
  assign gnt = obi.req && (wait_cnt_q >= wait_q);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wait_cnt_q <= '0;
      rvalid_q   <= 1'b0;
    end else begin
      rvalid_q <= gnt;
      if (gnt) begin
        wait_cnt_q <= '0;
      end else if (obi.req) begin
        wait_cnt_q <= wait_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt) begin
      rdata_q <= obi.we ? '0 : mem_q[idx];
      if (obi.we) begin
        for (int b = 0; b < ext_pkg::BE_W; b++) begin
          if (obi.be[b]) begin
            mem_q[idx][8*b +: 8] <= obi.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  assign obi.gnt    = gnt;
  assign obi.rvalid = rvalid_q;
  assign obi.rdata  = rdata_q;

  // wait-state config register
  assign is_wait = cfg.addr[ext_pkg::REG_IDX_MSB:ext_pkg::REG_IDX_LSB] ==
                   ext_pkg::REG_WAIT_OFFSET[ext_pkg::REG_IDX_MSB:ext_pkg::REG_IDX_LSB];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wait_q <= '0;
    end else if (cfg.valid && cfg.write && is_wait) begin
      wait_q <= cfg.wdata[ext_pkg::WAIT_W-1:0];
    end
  end

  assign cfg.ready = cfg.valid;

  always_comb begin
    cfg.rdata = '0;
    if (is_wait) begin
      cfg.rdata[ext_pkg::WAIT_W-1:0] = wait_q;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/ext_periph_top.sv ====
// external peripheral top
// register decoder with power switch and memory config targets, plus the
// OBI request FIFO in front of the slow memory
`default_nettype none

module ext_periph_top #(
  parameter int NUM_DOMAINS        = 4,
  parameter int SWITCH_ACK_LATENCY = 15,
  parameter int FIFO_DEPTH         = 4,
  parameter int MEM_WORDS          = 1024
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  output logic [NUM_DOMAINS-1:0] pg_switch_n_o,

  input  logic                   reg_valid_i,
  input  logic                   reg_write_i,
  input  ext_pkg::addr_t         reg_addr_i,
  input  ext_pkg::data_t         reg_wdata_i,
  output ext_pkg::data_t         reg_rdata_o,
  output logic                   reg_ready_o,
  output logic                   reg_error_o,

  input  logic                   obi_req_i,
  input  logic                   obi_we_i,
  input  ext_pkg::be_t           obi_be_i,
  input  ext_pkg::addr_t         obi_addr_i,
  input  ext_pkg::data_t         obi_wdata_i,
  output logic                   obi_gnt_o,
  output logic                   obi_rvalid_o,
  output ext_pkg::data_t         obi_rdata_o
);

  reg_bus_if pwr_bus ();
  reg_bus_if mem_cfg_bus ();
  obi_if     mem_obi ();

  logic [NUM_DOMAINS-1:0] switch_ack_n;

  reg_decode reg_decode_i (
    .reg_valid_i (reg_valid_i),
    .reg_write_i (reg_write_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .reg_ready_o (reg_ready_o),
    .reg_error_o (reg_error_o),
    .tgt_pwr     (pwr_bus),
    .tgt_mem     (mem_cfg_bus)
  );

  power_ctrl_regs #(
    .NUM_DOMAINS (NUM_DOMAINS)
  ) power_ctrl_regs_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .bus        (pwr_bus),
    .switch_n_o (pg_switch_n_o),
    .ack_n_i    (switch_ack_n)
  );

  // stands in for the switch cells of the gated domains
  switch_ack_delay #(
    .NUM_DOMAINS        (NUM_DOMAINS),
    .SWITCH_ACK_LATENCY (SWITCH_ACK_LATENCY)
  ) switch_ack_delay_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .switch_n_i (pg_switch_n_o),
    .ack_n_o    (switch_ack_n)
  );

  obi_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) obi_fifo_i (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .req_i    (obi_req_i),
    .we_i     (obi_we_i),
    .be_i     (obi_be_i),
    .addr_i   (obi_addr_i),
    .wdata_i  (obi_wdata_i),
    .gnt_o    (obi_gnt_o),
    .rvalid_o (obi_rvalid_o),
    .rdata_o  (obi_rdata_o),
    .down     (mem_obi)
  );

  slow_memory #(
    .MEM_WORDS (MEM_WORDS)
  ) slow_memory_i (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .obi     (mem_obi),
    .cfg     (mem_cfg_bus)
  );

endmodule

`default_nettype wire

// ==== tests/tb_ext_periph.sv ====
// testbench for the external peripheral top
// register decode, power switch acks and the OBI path to the slow memory
`default_nettype none

module tb_ext_periph;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_DOMAINS        = 4;
  localparam int SWITCH_ACK_LATENCY = 15;
  localparam int FIFO_DEPTH         = 4;
  localparam int MEM_WORDS          = 1024;
  localparam int TEST_WORDS         = 16;
  localparam int GNT_TIMEOUT        = 200;
  localparam int DRAIN_TIMEOUT      = 2000;

  localparam logic [31:0] SWITCH_ADDR = 32'h0000_0000;
  localparam logic [31:0] ACK_ADDR    = 32'h0000_0004;
  localparam logic [31:0] WAIT_ADDR   = 32'h0000_1000;
  localparam logic [31:0] UNMAPPED    = 32'h0000_2000;

  logic                   clk;
  logic                   reset;
  logic [NUM_DOMAINS-1:0] pg_switch_n;
  logic                   reg_valid;
  logic                   reg_write;
  logic [31:0]            reg_addr;
  logic [31:0]            reg_wdata;
  logic [31:0]            reg_rdata;
  logic                   reg_ready;
  logic                   reg_error;
  logic                   obi_req;
  logic                   obi_we;
  logic [3:0]             obi_be;
  logic [31:0]            obi_addr;
  logic [31:0]            obi_wdata;
  logic                   obi_gnt;
  logic                   obi_rvalid;
  logic [31:0]            obi_rdata;

  int          seed = 30541;
  int          checks = 0;
  int          errors = 0;
  int          issued_count = 0;
  int          rvalid_count = 0;
  bit          timed_out = 1'b0;
  logic [31:0] expected_q [$];
  logic [31:0] shadow [MEM_WORDS];
  logic [31:0] resp_exp;

  ext_periph_top #(
    .NUM_DOMAINS        (NUM_DOMAINS),
    .SWITCH_ACK_LATENCY (SWITCH_ACK_LATENCY),
    .FIFO_DEPTH         (FIFO_DEPTH),
    .MEM_WORDS          (MEM_WORDS)
  ) dut (
    .clk_i         (clk),
    .reset_i       (reset),
    .pg_switch_n_o (pg_switch_n),
    .reg_valid_i   (reg_valid),
    .reg_write_i   (reg_write),
    .reg_addr_i    (reg_addr),
    .reg_wdata_i   (reg_wdata),
    .reg_rdata_o   (reg_rdata),
    .reg_ready_o   (reg_ready),
    .reg_error_o   (reg_error),
    .obi_req_i     (obi_req),
    .obi_we_i      (obi_we),
    .obi_be_i      (obi_be),
    .obi_addr_i    (obi_addr),
    .obi_wdata_i   (obi_wdata),
    .obi_gnt_o     (obi_gnt),
    .obi_rvalid_o  (obi_rvalid),
    .obi_rdata_o   (obi_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // mapped accesses never see an error
  assert property (@(posedge clk) disable iff (reset)
    (reg_valid && reg_addr < UNMAPPED) |-> !reg_error)
    else begin
      errors++;
      $display("FAIL t=%0t reg_error_o expected 0 got %0b", $time, $sampled(reg_error));
    end

  assert property (@(posedge clk) disable iff (reset)
    (reg_valid && reg_addr >= UNMAPPED) |-> (reg_error && reg_ready && reg_rdata == '0))
    else begin
      errors++;
      $display("FAIL t=%0t reg_ready_o/reg_error_o/reg_rdata_o expected 1/1/%h got %0b/%0b/%h",
               $time, 32'h0, $sampled(reg_ready), $sampled(reg_error), $sampled(reg_rdata));
    end

  assert property (@(posedge clk) disable iff (reset)
    dut.obi_fifo_i.cnt_q <= FIFO_DEPTH)
    else begin
      errors++;
      $display("FAIL t=%0t fifo fill level expected <= %0d got %0d", $time, FIFO_DEPTH,
               $sampled(dut.obi_fifo_i.cnt_q));
    end

  // nothing outstanding means no response
  assert property (@(posedge clk) disable iff (reset)
    (issued_count == rvalid_count) |-> !obi_rvalid)
    else begin
      errors++;
      $display("FAIL t=%0t obi_rvalid_o expected 0 got %0b", $time, $sampled(obi_rvalid));
    end

  // in-order response checker
  always @(posedge clk) begin
    if (!reset && obi_rvalid) begin
      rvalid_count++;
      if (expected_q.size() == 0) begin
        errors++;
        $display("response at t=%0t arrived with no request outstanding", $time);
      end else begin
        resp_exp = expected_q.pop_front();
        expect_equal("obi_rdata_o", obi_rdata, resp_exp);
      end
    end
  end

  task automatic expect_equal(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  // one register access with the response sampled at the accepting edge
  task automatic reg_access(input logic write, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic error);
    @(negedge clk);
    reg_valid = 1'b1;
    reg_write = write;
    reg_addr  = addr;
    reg_wdata = wdata;
    @(posedge clk);
    expect_equal("reg_ready_o", {31'b0, reg_ready}, 32'd1);
    rdata = reg_rdata;
    error = reg_error;
  endtask

  task automatic reg_idle();
    @(negedge clk);
    reg_valid = 1'b0;
    reg_write = 1'b0;
  endtask

  task automatic reg_store(input logic [31:0] addr, input logic [31:0] wdata);
    logic [31:0] rdata;
    logic        error;
    reg_access(1'b1, addr, wdata, rdata, error);
  endtask

  task automatic reg_check(input logic [31:0] addr, input logic [31:0] exp,
                           input string name);
    logic [31:0] rdata;
    logic        error;
    reg_access(1'b0, addr, 32'h0, rdata, error);
    expect_equal(name, rdata, exp);
  endtask

  task automatic decode_error(input logic write, input logic [31:0] addr);
    logic [31:0] rdata;
    logic        error;
    reg_access(write, addr, $random(seed), rdata, error);
    expect_equal("reg_error_o", {31'b0, error}, 32'd1);
    expect_equal("reg_rdata_o", rdata, 32'h0);
  endtask

  // ack must follow the switch exactly SWITCH_ACK_LATENCY cycles later
  task automatic switch_domains(input logic [NUM_DOMAINS-1:0] old_sw,
                                input logic [NUM_DOMAINS-1:0] new_sw);
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        error;
    wdata = $random(seed);
    wdata[NUM_DOMAINS-1:0] = new_sw;
    reg_store(SWITCH_ADDR, wdata);
    for (int k = 0; k <= SWITCH_ACK_LATENCY + 1; k++) begin
      reg_access(1'b0, ACK_ADDR, 32'h0, rdata, error);
      expect_equal("pg_switch_n_o", 32'(pg_switch_n), 32'(new_sw));
      if (k < SWITCH_ACK_LATENCY) begin
        expect_equal("REG_ACK", rdata, 32'(old_sw));
      end else begin
        expect_equal("REG_ACK", rdata, 32'(new_sw));
      end
    end
    reg_check(SWITCH_ADDR, 32'(new_sw), "REG_SWITCH");
    reg_idle();
  endtask

  // issue one request, hold it until granted, then record the expected response
  task automatic obi_request(input logic we, input logic [3:0] be, input int word,
                             input logic [31:0] wdata);
    int          waited;
    logic [31:0] merged;
    waited = 0;
    @(negedge clk);
    obi_req   = 1'b1;
    obi_we    = we;
    obi_be    = be;
    obi_addr  = 32'(word * 4);
    obi_wdata = wdata;
    @(posedge clk);
    while (!obi_gnt && waited < GNT_TIMEOUT) begin
      waited++;
      @(posedge clk);
    end
    if (!obi_gnt) begin
      errors++;
      timed_out = 1'b1;
      $display("timeout at t=%0t, no OBI grant within %0d cycles", $time, GNT_TIMEOUT);
      return;
    end
    issued_count++;
    if (we) begin
      merged = shadow[word];
      for (int b = 0; b < 4; b++) begin
        if (be[b]) begin
          merged[8*b +: 8] = wdata[8*b +: 8];
        end
      end
      shadow[word] = merged;
      expected_q.push_back(32'h0);
    end else begin
      expected_q.push_back(shadow[word]);
    end
  endtask

  task automatic drain_responses();
    int waited;
    waited = 0;
    @(negedge clk);
    obi_req = 1'b0;
    while (rvalid_count != issued_count && waited < DRAIN_TIMEOUT) begin
      waited++;
      @(posedge clk);
    end
    if (rvalid_count != issued_count) begin
      errors++;
      timed_out = 1'b1;
      $display("timeout at t=%0t, %0d responses still missing", $time,
               issued_count - rvalid_count);
      return;
    end
    // a few idle cycles catch any extra response
    repeat (4) @(posedge clk);
    expect_equal("obi_rvalid_o count", rvalid_count, issued_count);
    expect_equal("pending responses", expected_q.size(), 32'd0);
  endtask

  // full writes, then mixed byte-enable traffic, then read-back of every word
  task automatic memory_phase();
    int          words [TEST_WORDS];
    int          word;
    logic        we;
    logic [3:0]  be;
    for (int i = 0; i < TEST_WORDS; i++) begin
      words[i] = $unsigned($random(seed)) % MEM_WORDS;
      obi_request(1'b1, 4'hf, words[i], $random(seed));
      if (timed_out) return;
    end
    for (int i = 0; i < 3 * TEST_WORDS; i++) begin
      word = words[$unsigned($random(seed)) % TEST_WORDS];
      we   = 1'($random(seed));
      be   = 4'($random(seed));
      obi_request(we, be, word, $random(seed));
      if (timed_out) return;
    end
    for (int i = 0; i < TEST_WORDS; i++) begin
      obi_request(1'b0, 4'hf, words[i], 32'h0);
      if (timed_out) return;
    end
    drain_responses();
  endtask

  task automatic run_tests();
    logic [NUM_DOMAINS-1:0] old_sw;
    logic [NUM_DOMAINS-1:0] new_sw;
    @(posedge clk);
    expect_equal("pg_switch_n_o", 32'(pg_switch_n), 32'h0);
    expect_equal("obi_gnt_o", {31'b0, obi_gnt}, 32'd1);
    expect_equal("obi_rvalid_o", {31'b0, obi_rvalid}, 32'd0);
    reg_check(SWITCH_ADDR, 32'h0, "REG_SWITCH");
    reg_check(ACK_ADDR, 32'h0, "REG_ACK");
    reg_check(WAIT_ADDR, 32'h0, "REG_WAIT");
    reg_idle();

    old_sw = '0;
    repeat (2) begin
      new_sw = NUM_DOMAINS'($random(seed));
      if (new_sw == old_sw) begin
        new_sw = ~old_sw;
      end
      switch_domains(old_sw, new_sw);
      old_sw = new_sw;
    end

    // unmapped accesses must leave the registers alone
    decode_error(1'b0, UNMAPPED);
    decode_error(1'b1, UNMAPPED | $random(seed));
    decode_error(1'b0, 32'hffff_fffc);
    reg_check(SWITCH_ADDR, 32'(old_sw), "REG_SWITCH");
    reg_idle();

    memory_phase();
    if (timed_out) return;

    reg_store(WAIT_ADDR, 32'd7);
    reg_check(WAIT_ADDR, 32'd7, "REG_WAIT");
    reg_idle();
    memory_phase();
  endtask

  initial begin
    reset     = 1'b1;
    reg_valid = 1'b0;
    reg_write = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    obi_req   = 1'b0;
    obi_we    = 1'b0;
    obi_be    = '0;
    obi_addr  = '0;
    obi_wdata = '0;
    repeat (8) @(negedge clk);
    reset = 1'b0;

    run_tests();

    $display("checks: %0d, errors: %0d, requests: %0d, responses: %0d",
             checks, errors, issued_count, rvalid_count);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
verilog/ext_pkg.sv
verilog/ext_ifs.sv
verilog/reg_decode.sv
verilog/power_ctrl_regs.sv
verilog/switch_ack_delay.sv
verilog/obi_fifo.sv
verilog/slow_memory.sv
verilog/ext_periph_top.sv
tests/tb_ext_periph.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the external peripheral testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_ext_periph \
  -f list.f -o Vtb_ext_periph
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/Vtb_ext_periph > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
  exit 0
fi
exit 1
